/* fetch_unit.f */
logic/fetch_pkg.sv
logic/axi_rd_pkg.sv
logic/fill_if.sv
logic/fetch_pc.sv
logic/icache_lookup.sv
logic/axi_block_reader.sv
logic/fetch_unit.sv
testbench/tb_axi_memory.sv
testbench/tb_fetch_unit.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  - files:
      - logic/fetch_pkg.sv
      - logic/axi_rd_pkg.sv
      - logic/fill_if.sv
      - logic/fetch_pc.sv
      - logic/icache_lookup.sv
      - logic/axi_block_reader.sv
      - logic/fetch_unit.sv
  - target: test
    files:
      - testbench/tb_axi_memory.sv
      - testbench/tb_fetch_unit.sv

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_unit;

    localparam int          block_words    = 4;
    localparam int          sets           = 16;
    localparam int          timeout_cycles = 200;
    localparam logic [31:0] pattern        = 32'h5A5A_5A5A; // Word at A is A XOR pattern.

    logic        clk = 1'b0;
    logic        rst;
    logic        decode_ready;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        inst_valid;
    logic [31:0] inst_pc;
    logic [31:0] inst;
    logic        access_fault;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic [15:0] lfsr = 16'd38;

    fetch_unit #(
        .block_words (block_words),
        .sets        (sets)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .decode_ready   (decode_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst           (inst),
        .access_fault   (access_fault),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rlast          (rlast)
    );

    tb_axi_memory axi_mem (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first failing check.");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_inst(input logic [31:0] pc, input logic [31:0] data, input logic fault,
                              input logic [31:0] exp_pc, input logic exp_fault);
        check_word("inst_pc", pc, exp_pc);
        check_word("access_fault", 32'(fault), 32'(exp_fault));
        check_word("inst", data, exp_fault ? 32'd0 : exp_pc ^ pattern); // Faults carry zero.
    endtask

    // Returns on the falling edge inside the inst_valid pulse.
    task automatic wait_inst(output logic [31:0] pc, output logic [31:0] data, output logic fault);
        logic found;
        found = 1'b0;
        for (int n = 0; n < timeout_cycles && !found; n++) begin
            @(negedge clk);
            if (inst_valid) begin
                found = 1'b1;
                pc    = inst_pc;
                data  = inst;
                fault = access_fault;
            end
        end
        assert (found) else begin
            $display("Timeout: no inst_valid within %0d cycles", timeout_cycles);
            abort_run();
        end
    endtask

    // Execute's answer rides along with the instruction just delivered.
    task automatic redirect_to(input logic [31:0] target, input logic ready);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        decode_ready   = ready;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic sequential_from_reset();
        logic [31:0] pc;
        logic [31:0] data;
        logic        fault;
        assert (!inst_valid && !access_fault && !arvalid && !rready) else begin
            $display("Outputs are not idle after reset");
            abort_run();
        end
        decode_ready = 1'b1;
        for (int i = 0; i < 2 * block_words; i++) begin
            wait_inst(pc, data, fault);
            check_inst(pc, data, fault, fetch_pkg::reset_pc + fetch_pkg::word_bytes * 32'(i), 1'b0);
        end
    endtask

    task automatic single_reads_outside_sdram();
        check_word("address phase count", 32'(axi_mem.ar_addr_log.size()), 32'(2 * block_words));
        for (int k = 0; k < block_words; k++) begin
            check_word("araddr", axi_mem.ar_addr_log[k], fetch_pkg::reset_pc + 32'(4 * k));
            check_word("arlen", 32'(axi_mem.ar_len_log[k]), 32'd0);
            check_word("arburst", 32'(axi_mem.ar_burst_log[k]), 32'(axi_rd_pkg::burst_fixed));
        end
    endtask

    task automatic burst_refill_in_sdram();
        logic [31:0] target;
        logic [31:0] base;
        logic [31:0] pc;
        logic [31:0] data;
        logic        fault;
        int          n0;
        int          words_left;
        target     = 32'hA000_0010;
        base       = target - (target % (block_words * 4));
        words_left = block_words - int'((target - base) / 4);
        n0         = axi_mem.ar_addr_log.size();
        redirect_to(target, 1'b1);
        for (int k = 0; k < words_left; k++) begin
            wait_inst(pc, data, fault);
            check_inst(pc, data, fault, target + 32'(4 * k), 1'b0);
        end
        // The rest of the block hits, so only one address phase was issued.
        check_word("address phase count", 32'(axi_mem.ar_addr_log.size()), 32'(n0 + 1));
        check_word("araddr", axi_mem.ar_addr_log[n0], base);
        check_word("arlen", 32'(axi_mem.ar_len_log[n0]), 32'(block_words - 1));
        check_word("arburst", 32'(axi_mem.ar_burst_log[n0]), 32'(axi_rd_pkg::burst_incr));
        check_word("arsize", 32'(arsize), 32'(axi_rd_pkg::size_word));
    endtask

    task automatic hit_timing();
        logic [31:0] target;
        logic        found;
        int          n0;
        int          cycles;
        target = 32'hA000_0014;
        redirect_to(target, 1'b0);
        @(negedge clk);
        n0           = axi_mem.ar_addr_log.size();
        decode_ready = 1'b1;
        found        = 1'b0;
        cycles       = 0;
        while (!found && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            assert (!arvalid) else begin
                $display("AXI read started although the line is cached");
                abort_run();
            end
            found = inst_valid;
        end
        assert (found) else begin
            $display("Timeout: cached fetch never delivered");
            abort_run();
        end
        // The fetch starts one cycle after decode_ready rises and hits two cycles later.
        check_word("hit latency", 32'(cycles), 32'(1 + 2));
        check_inst(inst_pc, inst, access_fault, target, 1'b0);
        check_word("address phase count", 32'(axi_mem.ar_addr_log.size()), 32'(n0));
    endtask

    task automatic access_fault_refetch();
        logic [31:0] pc;
        logic [31:0] data;
        logic        fault;
        int          n0;
        for (int attempt = 0; attempt < 2; attempt++) begin
            n0 = axi_mem.ar_addr_log.size();
            redirect_to(32'hF000_0000, 1'b1);
            wait_inst(pc, data, fault);
            check_inst(pc, data, fault, 32'hF000_0000, 1'b1);
            check_word("address phase count", 32'(axi_mem.ar_addr_log.size()), 32'(n0 + 1));
        end
    endtask

    task automatic decode_stall();
        logic [31:0] pc;
        logic [31:0] data;
        logic        fault;
        int          stall_cycles;
        int          seen;
        redirect_to(fetch_pkg::reset_pc, 1'b1);
        wait_inst(pc, data, fault);
        check_inst(pc, data, fault, fetch_pkg::reset_pc, 1'b0);
        // Long enough that a fetch ignoring decode_ready would show up.
        stall_cycles = 8;
        for (int b = 0; b < 6; b++) begin
            stall_cycles += int'(next_random_bit()) << b;
        end
        @(negedge clk);
        @(negedge clk); // Next fetch is in flight by now.
        decode_ready = 1'b0;
        seen         = 0;
        for (int c = 0; c < stall_cycles; c++) begin
            @(negedge clk);
            if (inst_valid) begin
                seen++;
                check_inst(inst_pc, inst, access_fault, fetch_pkg::reset_pc + 32'd4, 1'b0);
            end
        end
        check_word("inst_valid count during stall", 32'(seen), 32'd1);
        decode_ready = 1'b1;
        for (int k = 2; k < 5; k++) begin
            wait_inst(pc, data, fault);
            check_inst(pc, data, fault, fetch_pkg::reset_pc + 32'(4 * k), 1'b0);
        end
    endtask

    initial begin
        rst            = 1'b1;
        decode_ready   = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        sequential_from_reset();
        single_reads_outside_sdram();
        burst_refill_in_sdram();
        hit_timing();
        access_fault_refetch();
        decode_stall();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_axi_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_memory (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        arvalid,
    output logic             arready,
    input  wire logic [31:0] araddr,
    input  wire logic [7:0]  arlen,
    input  wire logic [1:0]  arburst,
    output logic             rvalid,
    input  wire logic        rready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             rlast
);

    localparam logic [1:0] resp_slverr = 2'b10;

    // Every accepted address phase, in order.
    logic [31:0] ar_addr_log [$];
    logic [7:0]  ar_len_log [$];
    logic [1:0]  ar_burst_log [$];

    logic [15:0] lfsr = 16'd38;
    logic [31:0] beat_addr;
    logic        incr;
    int          beats_left;

    // Taps 16, 14, 13 and 11.
    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    initial begin
        arready    = 1'b0;
        rvalid     = 1'b0;
        rdata      = '0;
        rresp      = axi_rd_pkg::resp_okay;
        rlast      = 1'b0;
        incr       = 1'b0;
        beat_addr  = '0;
        beats_left = 0;
        forever begin
            @(negedge clk);
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
            if (rst) begin
                beats_left = 0;
            end else if (beats_left == 0) begin
                // A one-cycle arready pulse while arvalid is up completes at the next edge.
                if (arvalid && next_random_bit()) begin
                    arready    = 1'b1;
                    beat_addr  = araddr;
                    beats_left = int'(arlen) + 1;
                    incr       = (arburst == axi_rd_pkg::burst_incr);
                    ar_addr_log.push_back(araddr);
                    ar_len_log.push_back(arlen);
                    ar_burst_log.push_back(arburst);
                end
            end else if (rready && next_random_bit()) begin
                rvalid     = 1'b1; // Beat is taken at the next edge.
                rdata      = beat_addr ^ 32'h5A5A_5A5A;
                rresp      = (beat_addr >= 32'hF000_0000) ? resp_slverr : axi_rd_pkg::resp_okay;
                rlast      = (beats_left == 1);
                beat_addr  = incr ? beat_addr + 32'd4 : beat_addr;
                beats_left = beats_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter int block_words = 4,
    parameter int sets        = 16
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        decode_ready,
    input  wire logic        redirect_valid,
    input  wire logic [31:0] redirect_pc,
    output logic             inst_valid,
    output logic [31:0]      inst_pc,
    output logic [31:0]      inst,
    output logic             access_fault,
    output logic             arvalid,
    input  wire logic        arready,
    output logic [31:0]      araddr,
    output logic [7:0]       arlen,
    output logic [2:0]       arsize,
    output logic [1:0]       arburst,
    input  wire logic        rvalid,
    output logic             rready,
    input  wire logic [31:0] rdata,
    input  wire logic [1:0]  rresp,
    input  wire logic        rlast
);

    logic        lookup_req;
    logic [31:0] lookup_addr;
    logic        fetch_done;

    fill_if #(.block_words(block_words)) fill_bus ();

    fetch_pc u_pc (
        .clk            (clk),
        .rst            (rst),
        .decode_ready   (decode_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_done     (fetch_done),
        .lookup_req     (lookup_req),
        .lookup_addr    (lookup_addr)
    );

    icache_lookup #(
        .block_words (block_words),
        .sets        (sets)
    ) u_icache (
        .clk          (clk),
        .rst          (rst),
        .lookup_req   (lookup_req),
        .lookup_addr  (lookup_addr),
        .fill         (fill_bus.cache),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst         (inst),
        .access_fault (access_fault),
        .fetch_done   (fetch_done)
    );

    axi_block_reader #(.block_words(block_words)) u_reader (
        .clk     (clk),
        .rst     (rst),
        .fill    (fill_bus.reader),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

endmodule

`default_nettype wire

/* logic/axi_block_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_block_reader #(
    parameter int block_words = 4
) (
    input  wire logic        clk,
    input  wire logic        rst,
    fill_if.reader           fill,
    output logic             arvalid,
    input  wire logic        arready,
    output logic [31:0]      araddr,
    output logic [7:0]       arlen,
    output logic [2:0]       arsize,
    output logic [1:0]       arburst,
    input  wire logic        rvalid,
    output logic             rready,
    input  wire logic [31:0] rdata,
    input  wire logic [1:0]  rresp,
    input  wire logic        rlast
);

    localparam int off_w  = $clog2(block_words);
    localparam int off_ws = (off_w > 0) ? off_w : 1;
    localparam logic [off_ws-1:0] last_idx = off_ws'(block_words - 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_addr  = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_drain = 2'd3; // Swallow the tail of a failed burst.

    logic [1:0]        state;
    logic [off_ws-1:0] beat;
    logic              req_wait;
    logic              start;
    logic              in_sdram;
    logic              is_burst;
    logic              beat_err;
    logic              last_beat;

    assign in_sdram  = (fill.addr >= fetch_pkg::sdram_base) &&
                       (fill.addr <= fetch_pkg::sdram_end);
    assign start     = (state == st_idle) && (fill.req || req_wait);
    assign is_burst  = (arburst == axi_rd_pkg::burst_incr);
    assign beat_err  = (rresp != axi_rd_pkg::resp_okay);
    assign last_beat = is_burst ? rlast : (beat == last_idx);
    assign arsize    = axi_rd_pkg::size_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            beat      <= '0;
            req_wait  <= 1'b0;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            fill.done <= 1'b0;
        end else begin
            fill.done <= 1'b0;
            if (fill.req && state != st_idle) req_wait <= 1'b1;
            case (state)
                st_idle: begin
                    if (start) begin
                        req_wait <= 1'b0;
                        beat     <= '0;
                        arvalid  <= 1'b1;
                        state    <= st_addr;
                    end
                end
                st_addr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= st_data;
                    end
                end
                st_data: begin
                    if (rvalid) begin
                        if (beat_err) begin
                            fill.done <= 1'b1;
                            if (is_burst && !rlast) begin
                                state <= st_drain;
                            end else begin
                                rready <= 1'b0;
                                state  <= st_idle;
                            end
                        end else if (last_beat) begin
                            fill.done <= 1'b1;
                            rready    <= 1'b0;
                            state     <= st_idle;
                        end else begin
                            beat <= beat + 1'b1;
                            if (!is_burst) begin // Next single read.
                                rready  <= 1'b0;
                                arvalid <= 1'b1;
                                state   <= st_addr;
                            end
                        end
                    end
                end
                default: begin
                    if (rvalid && rlast) begin
                        rready <= 1'b0;
                        state  <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            araddr  <= fill.addr;
            arlen   <= in_sdram ? 8'(block_words - 1) : 8'd0;
            arburst <= in_sdram ? axi_rd_pkg::burst_incr : axi_rd_pkg::burst_fixed;
        end else if (state == st_data && rvalid && !beat_err && !last_beat && !is_burst) begin
            araddr <= araddr + fetch_pkg::word_bytes;
        end
        if (state == st_data && rvalid) begin
            fill.block[beat] <= rdata;
            fill.fault       <= beat_err;
        end
    end

    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    // A burst ends only on its final beat.
    a_rlast_count: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_data) && rvalid && rlast && is_burst |-> beat == last_idx
    );

endmodule

`default_nettype wire

/* logic/icache_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_lookup #(
    parameter int block_words = 4,
    parameter int sets        = 16
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        lookup_req,
    input  wire logic [31:0] lookup_addr,
    fill_if.cache            fill,
    output logic             inst_valid,
    output logic [31:0]      inst_pc,
    output logic [31:0]      inst,
    output logic             access_fault,
    output logic             fetch_done
);

    localparam int off_w  = $clog2(block_words);
    localparam int idx_w  = $clog2(sets);
    localparam int off_ws = (off_w > 0) ? off_w : 1;
    localparam int idx_ws = (idx_w > 0) ? idx_w : 1;
    localparam int tag_w  = 30 - off_w - idx_w;

    logic [sets-1:0]              line_valid;
    logic [tag_w-1:0]             tags [sets];
    logic [block_words-1:0][31:0] lines [sets];

    logic              look_q;       // Array read cycle.
    logic [31:0]       addr_q;
    logic              miss_pending;
    logic [idx_ws-1:0] idx_q;
    logic [off_ws-1:0] word_q;
    logic [tag_w-1:0]  tag_q;
    logic              hit;

    assign idx_q  = idx_ws'((addr_q >> (2 + off_w)) & (sets - 1));
    assign word_q = off_ws'((addr_q >> 2) & (block_words - 1));
    assign tag_q  = addr_q[31 -: tag_w];

    assign hit = look_q && line_valid[idx_q] && (tags[idx_q] == tag_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            look_q       <= 1'b0;
            miss_pending <= 1'b0;
            fill.req     <= 1'b0;
            inst_valid   <= 1'b0;
            access_fault <= 1'b0;
            line_valid   <= '0;
        end else begin
            look_q       <= lookup_req;
            fill.req     <= 1'b0;
            inst_valid   <= 1'b0;
            access_fault <= 1'b0;
            if (look_q) begin
                if (hit) begin
                    inst_valid <= 1'b1;
                end else begin
                    fill.req     <= 1'b1;
                    miss_pending <= 1'b1;
                end
            end
            if (fill.done) begin
                miss_pending <= 1'b0;
                inst_valid   <= 1'b1;
                access_fault <= fill.fault;
                if (!fill.fault) line_valid[idx_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req) addr_q <= lookup_addr;
        if (look_q && !hit) begin
            fill.addr <= addr_q & ~(32'(block_words) * fetch_pkg::word_bytes - 32'd1);
        end
        if (hit) begin
            inst_pc <= addr_q;
            inst    <= lines[idx_q][word_q];
        end
        if (fill.done) begin
            inst_pc <= addr_q;
            inst    <= fill.fault ? 32'd0 : fill.block[word_q]; // Faults deliver zero.
        end
        // A faulting block never lands in the arrays.
        if (fill.done && !fill.fault) begin
            tags[idx_q]  <= tag_q;
            lines[idx_q] <= fill.block;
        end
    end

    assign fetch_done = inst_valid;

    // The reader answers only outstanding misses.
    a_done_on_miss: assert property (
        @(posedge clk) disable iff (rst)
        fill.done |-> miss_pending
    );

endmodule

`default_nettype wire

/* logic/fetch_pc.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_pc (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        decode_ready,
    input  wire logic        redirect_valid,
    input  wire logic [31:0] redirect_pc,
    input  wire logic        fetch_done,
    output logic             lookup_req,
    output logic [31:0]      lookup_addr
);

    logic [31:0] pc;
    logic        busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc         <= fetch_pkg::reset_pc;
            busy       <= 1'b0;
            lookup_req <= 1'b0;
        end else begin
            lookup_req <= 1'b0;
            if (fetch_done) begin
                // Execute's decision arrives together with the returned instruction.
                busy <= 1'b0;
                pc   <= redirect_valid ? redirect_pc : pc + fetch_pkg::word_bytes;
            end else if (!busy && decode_ready) begin
                busy       <= 1'b1;
                lookup_req <= 1'b1;
            end
        end
    end

    assign lookup_addr = pc;

    // Only one fetch may be outstanding, so every completion belongs to it.
    a_single_fetch: assert property (
        @(posedge clk) disable iff (rst)
        fetch_done |-> busy
    );

endmodule

`default_nettype wire

/* logic/fill_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface fill_if #(
    parameter int block_words = 4
) ();

    logic                         req;   // One-cycle request pulse.
    logic [31:0]                  addr;  // Block aligned, held until done.
    logic                         done;  // One-cycle completion pulse.
    logic [block_words-1:0][31:0] block;
    logic                         fault;

    modport cache (
        output req, addr,
        input  done, block, fault
    );

    modport reader (
        input  req, addr,
        output done, block, fault
    );

endinterface

`default_nettype wire

/* logic/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;

    localparam logic [2:0] size_word = 3'b010; // Four bytes per beat.

    localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // Boot ROM entry point.
    localparam logic [31:0] reset_pc = 32'h3000_0000;

    // Refills inside this window use INCR bursts, elsewhere single beats.
    localparam logic [31:0] sdram_base = 32'hA000_0000;
    localparam logic [31:0] sdram_end  = 32'hBFFF_FFFF;

    localparam logic [31:0] word_bytes = 32'd4; // Bytes per instruction.

endpackage

`default_nettype wire
